//--- sim.f
+incdir+verilog
verilog/rv_isa_pkg.sv
verilog/rv_core_pkg.sv
verilog/fetch_unit.sv
verilog/pipe_reg.sv
verilog/instr_decoder.sv
verilog/register_file.sv
verilog/jump_branch_unit.sv
verilog/rv_front_end.sv
testbench/rv_front_end_sva.sv
testbench/rv_front_end_tb.sv

//--- Bender.yml
package:
  name: rv_front_end

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/rv_isa_pkg.sv
      - verilog/rv_core_pkg.sv
      - verilog/fetch_unit.sv
      - verilog/pipe_reg.sv
      - verilog/instr_decoder.sv
      - verilog/register_file.sv
      - verilog/jump_branch_unit.sv
      - verilog/rv_front_end.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - testbench/rv_front_end_sva.sv
      - testbench/rv_front_end_tb.sv

//--- testbench/rv_front_end_tb.sv
`timescale 1ns/1ps
`include "rv_front_consts.svh"

module rv_front_end_tb;

    localparam int PRELOAD_CYCLES = 10;

    typedef struct packed {
        logic [`XLEN-1:0] word;
        logic             valid;
        logic             follows_taken;    // Fetched alongside a taken row
        logic             exp_taken;
    } row_t;

    logic                    clk = 1'b0;
    logic                    rst_n;
    logic [`XLEN-1:0]        fetch_pc;
    rv_core_pkg::redirect_t  redirect;
    logic [`XLEN-1:0]        instr_word;
    logic                    instr_valid;
    rv_core_pkg::reg_write_t reg_write;

    row_t        rows[$];
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          limit = 1000;
    int          resolved = 0;
    logic [31:0] rng = 32'd1;

    // Reference model, state as seen after each clock edge
    logic [`XLEN-1:0]        m_pc;
    logic                    m_fd_valid;
    logic [`XLEN-1:0]        m_fd_pc;
    logic [`XLEN-1:0]        m_fd_word;
    int                      m_fd_row;
    rv_core_pkg::reg_write_t m_wb;
    logic [`XLEN-1:0]        m_regs [`NUM_REGS];

    rv_front_end rv_front_end_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_pc    (fetch_pc),
        .redirect    (redirect),
        .instr_word  (instr_word),
        .instr_valid (instr_valid),
        .reg_write   (reg_write)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("Timeout: run did not finish within %0d cycles", limit);
            $display("TB FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic logic [31:0] encode_branch(input logic [2:0] f3, input logic [4:0] rs1,
                                                  input logic [4:0] rs2, input int off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] encode_jal(input int off);
        return {off[20], off[10:1], off[11], off[19:12], 5'd0, 7'b1101111};
    endfunction

    function automatic rv_core_pkg::reg_write_t make_write(input logic [4:0] addr,
                                                           input logic [31:0] data);
        rv_core_pkg::reg_write_t w;
        w.en   = 1'b1;
        w.addr = addr;
        w.data = data;
        return w;
    endfunction

    // Branch and JAL offsets per the RV32I encoding
    function automatic logic [31:0] control_imm(input logic [31:0] w);
        logic [31:0] imm;
        imm = 32'd0;
        if (w[6:0] == 7'b1100011) begin
            imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        end else if (w[6:0] == 7'b1101111) begin
            imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        end
        return imm;
    endfunction

    function automatic logic condition_holds(input logic [31:0] w, input logic [31:0] a,
                                             input logic [31:0] b);
        logic hit;
        hit = 1'b0;
        if (w[6:0] == 7'b1101111) begin
            hit = 1'b1;
        end else if (w[6:0] == 7'b1100011) begin
            case (w[14:12])
                3'b000:  hit = (a == b);
                3'b001:  hit = (a != b);
                3'b100:  hit = ($signed(a) < $signed(b));
                3'b101:  hit = ($signed(a) >= $signed(b));
                3'b110:  hit = (a < b);
                3'b111:  hit = (a >= b);
                default: hit = 1'b0;
            endcase
        end
        return hit;
    endfunction

    task automatic expect_equal(input logic [31:0] actual, input logic [31:0] expected,
                                input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic add_row(input logic [31:0] word, input logic valid, input logic follows,
                           input logic exp_taken);
        row_t r;
        r.word          = word;
        r.valid         = valid;
        r.follows_taken = follows;
        r.exp_taken     = exp_taken;
        rows.push_back(r);
    endtask

    // x1=5 x2=5 x3=-3 x4=7 x5=INT_MIN x6=1, x7 never written
    task automatic build_table();
        add_row(32'h0010_8093, 1'b1, 1'b0, 1'b0);                 // ADDI
        add_row(encode_branch(3'b000, 1, 2, 16), 1'b1, 1'b0, 1'b1);
        add_row(encode_branch(3'b000, 1, 2, 32), 1'b1, 1'b1, 1'b1); // Would be taken
        add_row(encode_branch(3'b000, 1, 4, 16), 1'b1, 1'b0, 1'b0);
        add_row(encode_branch(3'b001, 1, 4, -8), 1'b1, 1'b0, 1'b1);
        add_row(encode_jal(64), 1'b1, 1'b1, 1'b1);
        add_row(encode_branch(3'b001, 1, 2, 8), 1'b1, 1'b0, 1'b0);
        add_row(encode_branch(3'b100, 3, 1, 12), 1'b1, 1'b0, 1'b1);  // -3 < 5
        add_row(32'h0010_8093, 1'b1, 1'b1, 1'b0);
        add_row(encode_branch(3'b100, 1, 3, 12), 1'b1, 1'b0, 1'b0);
        add_row(encode_branch(3'b110, 1, 3, 20), 1'b1, 1'b0, 1'b1);  // 5 < 0xfffffffd
        add_row(32'h0000_0013, 1'b1, 1'b1, 1'b0);
        add_row(encode_branch(3'b110, 3, 1, 20), 1'b1, 1'b0, 1'b0);
        add_row(encode_branch(3'b101, 1, 3, -16), 1'b1, 1'b0, 1'b1);
        add_row(encode_branch(3'b001, 1, 4, 8), 1'b1, 1'b1, 1'b1);
        add_row(encode_branch(3'b101, 3, 1, 8), 1'b1, 1'b0, 1'b0);
        add_row(encode_branch(3'b101, 1, 2, 24), 1'b1, 1'b0, 1'b1);  // Equal is GE
        add_row(32'h1234_52b7, 1'b1, 1'b1, 1'b0);                 // LUI
        add_row(encode_branch(3'b111, 3, 1, 40), 1'b1, 1'b0, 1'b1);
        add_row(encode_jal(-12), 1'b1, 1'b1, 1'b1);
        add_row(encode_branch(3'b111, 1, 3, 40), 1'b1, 1'b0, 1'b0);
        add_row(encode_jal(256), 1'b0, 1'b0, 1'b0);               // Stall, never captured
        add_row(encode_branch(3'b100, 5, 6, 8), 1'b1, 1'b0, 1'b1);
        add_row(32'h0020_a023, 1'b1, 1'b1, 1'b0);                 // SW
        add_row(encode_branch(3'b110, 5, 6, 8), 1'b1, 1'b0, 1'b0);
        add_row(encode_branch(3'b010, 1, 2, 8), 1'b1, 1'b0, 1'b0);   // Undefined funct3
        add_row(encode_branch(3'b011, 1, 2, 8), 1'b1, 1'b0, 1'b0);
        add_row(32'h0020_81b3, 1'b1, 1'b0, 1'b0);                 // ADD
        add_row(encode_jal(2048), 1'b1, 1'b0, 1'b1);
        add_row(encode_branch(3'b000, 0, 0, 4), 1'b1, 1'b1, 1'b1);
        add_row(encode_branch(3'b000, 0, 7, 12), 1'b1, 1'b0, 1'b1);  // x0 after write
        add_row(32'h0010_8093, 1'b1, 1'b1, 1'b0);
        add_row(encode_jal(-4096), 1'b1, 1'b0, 1'b1);
        add_row(encode_branch(3'b111, 5, 6, 4), 1'b1, 1'b1, 1'b1);
        add_row(32'h0000_0013, 1'b1, 1'b0, 1'b0);
    endtask

    task automatic run_cycle(input logic valid, input logic [`XLEN-1:0] word, input int row,
                             input rv_core_pkg::reg_write_t wr);
        logic             exp_taken;
        logic [`XLEN-1:0] exp_target;
        @(posedge clk);
        instr_valid <= valid;
        instr_word  <= word;
        reg_write   <= wr;
        @(negedge clk);
        exp_taken  = m_fd_valid &&
                     condition_holds(m_fd_word, m_regs[m_fd_word[19:15]], m_regs[m_fd_word[24:20]]);
        exp_target = m_fd_pc + control_imm(m_fd_word);
        expect_equal(fetch_pc, m_pc, "fetch_pc");
        expect_equal(redirect.taken, exp_taken, "redirect.taken");
        if (exp_taken) begin
            expect_equal(redirect.target, exp_target, "redirect.target");
        end
        if (m_fd_valid) begin
            resolved++;
            expect_equal(redirect.taken, rows[m_fd_row].exp_taken,
                         $sformatf("redirect.taken for table row %0d", m_fd_row));
        end
        if (m_wb.en && m_wb.addr != '0) begin
            m_regs[m_wb.addr] = m_wb.data;    // x0 stays zero
        end
        m_wb = wr;
        if (exp_taken) begin
            m_pc       = exp_target;
            m_fd_valid = 1'b0;    // Younger fetch dropped
        end else begin
            m_fd_valid = valid;
            if (valid) begin
                m_fd_pc   = m_pc;
                m_fd_word = word;
                m_fd_row  = row;
                m_pc      = m_pc + 32'd4;
            end
        end
    endtask

    initial begin
        int gaps;
        int expected_resolved;
        gaps              = 0;
        expected_resolved = 0;
        rst_n             = 1'b0;
        instr_valid       = 1'b0;
        instr_word        = '0;
        reg_write         = '0;
        m_pc              = `RESET_PC;
        m_fd_valid        = 1'b0;
        m_fd_pc           = '0;
        m_fd_word         = '0;
        m_fd_row          = -1;
        m_wb              = '0;
        foreach (m_regs[i]) begin
            m_regs[i] = '0;
        end
        build_table();
        limit = PRELOAD_CYCLES + rows.size() * 4 + 50;

        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        expect_equal(fetch_pc, `RESET_PC, "fetch_pc after reset");
        expect_equal(redirect.taken, 1'b0, "redirect.taken after reset");

        run_cycle(1'b0, '0, -1, make_write(5'd1, 32'd5));
        run_cycle(1'b0, '0, -1, make_write(5'd2, 32'd5));
        run_cycle(1'b0, '0, -1, make_write(5'd3, 32'hffff_fffd));
        run_cycle(1'b0, '0, -1, make_write(5'd4, 32'd7));
        run_cycle(1'b0, '0, -1, make_write(5'd5, 32'h8000_0000));
        run_cycle(1'b0, '0, -1, make_write(5'd6, 32'd1));
        run_cycle(1'b0, '0, -1, make_write(5'd0, 32'hdead_beef));
        repeat (3) run_cycle(1'b0, '0, -1, '0);

        foreach (rows[r]) begin
            if (!rows[r].follows_taken && (xorshift32() % 4) == 0) begin
                gaps = 1 + xorshift32() % 2;
                repeat (gaps) run_cycle(1'b0, xorshift32(), -1, '0);
            end
            run_cycle(rows[r].valid, rows[r].word, r, '0);
            if (rows[r].valid && !rows[r].follows_taken) begin
                expected_resolved++;
            end
        end
        repeat (4) run_cycle(1'b0, '0, -1, '0);
        expect_equal(resolved, expected_resolved, "resolved row count");

        $display("Checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
                 rv_front_end_i.front_end_sva_i.fail_count);
        if (errors == 0 && rv_front_end_i.front_end_sva_i.fail_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- testbench/rv_front_end_sva.sv
`timescale 1ns/1ps
`include "rv_front_consts.svh"

module rv_front_end_sva (
    input logic                   clk,
    input logic                   rst_n,
    input logic [`XLEN-1:0]       fetch_pc,
    input logic                   instr_valid,
    input rv_core_pkg::redirect_t redirect
);

    int fail_count = 0;    // Failed assertion count

    // Flush clears the stage, so a second redirect cannot follow
    property single_cycle_redirect;
        @(posedge clk) disable iff (!rst_n)
            redirect.taken |=> !redirect.taken;
    endproperty

    property pc_holds_on_stall;
        @(posedge clk) disable iff (!rst_n)
            (!instr_valid && !redirect.taken) |=> $stable(fetch_pc);
    endproperty

    property pc_follows_redirect;
        @(posedge clk) disable iff (!rst_n)
            redirect.taken |=> (fetch_pc == $past(redirect.target));
    endproperty

    single_redirect_a: assert property (single_cycle_redirect)
        else begin
            fail_count++;
            $error("redirect high for two cycles in a row");
        end

    stall_hold_a: assert property (pc_holds_on_stall)
        else begin
            fail_count++;
            $error("fetch_pc moved while instr_valid was low");
        end

    redirect_target_a: assert property (pc_follows_redirect)
        else begin
            fail_count++;
            $error("fetch_pc did not load the redirect target");
        end

endmodule

bind rv_front_end rv_front_end_sva front_end_sva_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .fetch_pc    (fetch_pc),
    .instr_valid (instr_valid),
    .redirect    (redirect)
);

//--- verilog/rv_front_end.sv
`timescale 1ns/1ps
`include "rv_front_consts.svh"

module rv_front_end (
    input  logic                    clk,
    input  logic                    rst_n,
    output logic [`XLEN-1:0]        fetch_pc,
    output rv_core_pkg::redirect_t  redirect,
    input  logic [`XLEN-1:0]        instr_word,
    input  logic                    instr_valid,
    input  rv_core_pkg::reg_write_t reg_write
);

    rv_core_pkg::fetch_bundle_t fetch_bundle;
    rv_core_pkg::fetch_bundle_t fd_data;
    logic                       fd_valid;

    rv_core_pkg::reg_write_t    wb_data;
    logic                       wb_valid;
    rv_core_pkg::reg_write_t    rf_wr;

    rv_isa_pkg::decoded_instr_t decoded;
    logic [`XLEN-1:0]           rs1_data;
    logic [`XLEN-1:0]           rs2_data;
    logic                       jb_taken;

    fetch_unit fetch_unit_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .redirect    (redirect),
        .fetch_pc    (fetch_pc)
    );

    assign fetch_bundle.pc    = fetch_pc;
    assign fetch_bundle.instr = instr_word;

    // Younger instruction dropped on a taken redirect
    pipe_reg #(.payload_t(rv_core_pkg::fetch_bundle_t)) fd_reg_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (instr_valid),
        .flush     (redirect.taken),
        .in_data   (fetch_bundle),
        .out_valid (fd_valid),
        .out_data  (fd_data)
    );

    pipe_reg #(.payload_t(rv_core_pkg::reg_write_t)) wb_reg_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (reg_write.en),
        .flush     (1'b0),
        .in_data   (reg_write),
        .out_valid (wb_valid),
        .out_data  (wb_data)
    );

    assign rf_wr.en   = wb_valid && wb_data.en;
    assign rf_wr.addr = wb_data.addr;
    assign rf_wr.data = wb_data.data;

    instr_decoder instr_decoder_i (
        .instr   (fd_data.instr),
        .decoded (decoded)
    );

    register_file register_file_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (decoded.rs1),
        .rs2_addr (decoded.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr       (rf_wr)
    );

    jump_branch_unit jump_branch_unit_i (
        .decoded  (decoded),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .taken    (jb_taken)
    );

    // Stale stage contents must not redirect
    assign redirect.taken  = fd_valid && jb_taken;
    assign redirect.target = fd_data.pc + decoded.imm;

endmodule

//--- verilog/jump_branch_unit.sv
`timescale 1ns/1ps
`include "rv_front_consts.svh"

module jump_branch_unit (
    input  rv_isa_pkg::decoded_instr_t decoded,
    input  logic [`XLEN-1:0]           rs1_data,
    input  logic [`XLEN-1:0]           rs2_data,
    output logic                       taken
);

    logic is_branch;
    logic is_jump;
    logic eq;
    logic lt_s;
    logic lt_u;
    logic branch_taken;

    assign is_branch = (decoded.instr_type == rv_isa_pkg::TYPE_B) &&
                       (decoded.opcode == rv_isa_pkg::OPC_BRANCH);
    assign is_jump   = (decoded.instr_type == rv_isa_pkg::TYPE_J);

    // Shared comparators, the six conditions reuse them
    assign eq   = (rs1_data == rs2_data);
    assign lt_s = ($signed(rs1_data) < $signed(rs2_data));
    assign lt_u = (rs1_data < rs2_data);

    always_comb begin
        branch_taken = 1'b0;
        if (is_branch) begin
            case (rv_isa_pkg::branch_funct3_e'(decoded.funct3))
                rv_isa_pkg::F3_BEQ:  branch_taken = eq;
                rv_isa_pkg::F3_BNE:  branch_taken = !eq;
                rv_isa_pkg::F3_BLT:  branch_taken = lt_s;
                rv_isa_pkg::F3_BGE:  branch_taken = !lt_s;
                rv_isa_pkg::F3_BLTU: branch_taken = lt_u;
                rv_isa_pkg::F3_BGEU: branch_taken = !lt_u;
                default:             branch_taken = 1'b0;    // funct3 010 and 011
            endcase
        end
    end

    // JAL is unconditional
    assign taken = is_jump || branch_taken;

endmodule

//--- verilog/register_file.sv
`timescale 1ns/1ps
`include "rv_front_consts.svh"

module register_file (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [`REG_ADDR_W-1:0]  rs1_addr,
    input  logic [`REG_ADDR_W-1:0]  rs2_addr,
    output logic [`XLEN-1:0]        rs1_data,
    output logic [`XLEN-1:0]        rs2_data,
    input  rv_core_pkg::reg_write_t wr
);

    logic [`XLEN-1:0] regs [`NUM_REGS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.en && wr.addr != '0) begin
            regs[wr.addr] <= wr.data;    // x0 never written
        end
    end

    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

endmodule

//--- verilog/instr_decoder.sv
`timescale 1ns/1ps
`include "rv_front_consts.svh"

module instr_decoder (
    input  logic [`XLEN-1:0]           instr,
    output rv_isa_pkg::decoded_instr_t decoded
);

    rv_isa_pkg::opcode_e     opcode;
    rv_isa_pkg::instr_type_e instr_type;
    logic [`XLEN-1:0]        imm_b;
    logic [`XLEN-1:0]        imm_j;

    assign opcode = rv_isa_pkg::opcode_e'(instr[6:0]);

    // Scattered immediate bits, bit 0 always zero
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        case (opcode)
            rv_isa_pkg::OPC_BRANCH: instr_type = rv_isa_pkg::TYPE_B;
            rv_isa_pkg::OPC_JAL:    instr_type = rv_isa_pkg::TYPE_J;
            rv_isa_pkg::OPC_STORE:  instr_type = rv_isa_pkg::TYPE_S;
            rv_isa_pkg::OPC_OP:     instr_type = rv_isa_pkg::TYPE_R;
            rv_isa_pkg::OPC_LUI,
            rv_isa_pkg::OPC_AUIPC:  instr_type = rv_isa_pkg::TYPE_U;
            rv_isa_pkg::OPC_OP_IMM,
            rv_isa_pkg::OPC_LOAD,
            rv_isa_pkg::OPC_JALR,
            rv_isa_pkg::OPC_SYSTEM: instr_type = rv_isa_pkg::TYPE_I;
            default:                instr_type = rv_isa_pkg::TYPE_NONE;
        endcase
    end

    always_comb begin
        decoded.instr_type = instr_type;
        decoded.opcode     = opcode;
        decoded.funct3     = instr[14:12];
        decoded.funct7     = instr[31:25];
        decoded.rs1        = instr[19:15];
        decoded.rs2        = instr[24:20];

        // Only control flow immediates matter in this stage
        case (instr_type)
            rv_isa_pkg::TYPE_B: decoded.imm = imm_b;
            rv_isa_pkg::TYPE_J: decoded.imm = imm_j;
            default:            decoded.imm = '0;
        endcase
    end

endmodule

//--- verilog/pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  logic     flush,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    logic     valid_q;
    payload_t data_q;

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= in_valid;    // Bubble when input idle
        end
    end

    // Payload only moves with a valid input
    always_ff @(posedge clk) begin
        if (in_valid) begin
            data_q <= in_data;
        end
    end

    assign out_valid = valid_q;
    assign out_data  = data_q;

endmodule

//--- verilog/fetch_unit.sv
`timescale 1ns/1ps
`include "rv_front_consts.svh"

module fetch_unit (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   instr_valid,
    input  rv_core_pkg::redirect_t redirect,
    output logic [`XLEN-1:0]       fetch_pc
);

    logic [`XLEN-1:0] pc_q;
    logic [`XLEN-1:0] pc_next;

    // Redirect beats stall, stall beats sequential
    always_comb begin
        if (redirect.taken) begin
            pc_next = redirect.target;
        end else if (instr_valid) begin
            pc_next = pc_q + `PC_STEP;
        end else begin
            pc_next = pc_q;    // Memory not ready
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q <= `RESET_PC;
        end else begin
            pc_q <= pc_next;
        end
    end

    assign fetch_pc = pc_q;

endmodule

//--- verilog/rv_core_pkg.sv
`include "rv_front_consts.svh"

package rv_core_pkg;

    // Fetch/decode stage payload
    typedef struct packed {
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] instr;
    } fetch_bundle_t;

    // Resolve stage back to fetch
    typedef struct packed {
        logic             taken;
        logic [`XLEN-1:0] target;
    } redirect_t;

    // External register write port
    typedef struct packed {
        logic                   en;
        logic [`REG_ADDR_W-1:0] addr;
        logic [`XLEN-1:0]       data;
    } reg_write_t;

endpackage

//--- verilog/rv_isa_pkg.sv
`include "rv_front_consts.svh"

package rv_isa_pkg;

    // Code 5 left unused
    typedef enum logic [2:0] {
        TYPE_I    = 3'd0,
        TYPE_B    = 3'd1,
        TYPE_S    = 3'd2,
        TYPE_U    = 3'd3,
        TYPE_J    = 3'd4,
        TYPE_R    = 3'd6,
        TYPE_NONE = 3'd7
    } instr_type_e;

    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_OP_IMM = 7'b0010011,
        OPC_AUIPC  = 7'b0010111,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JALR   = 7'b1100111,
        OPC_JAL    = 7'b1101111,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [2:0] {
        F3_BEQ  = 3'b000,
        F3_BNE  = 3'b001,
        F3_BLT  = 3'b100,
        F3_BGE  = 3'b101,
        F3_BLTU = 3'b110,
        F3_BGEU = 3'b111
    } branch_funct3_e;

    typedef struct packed {
        instr_type_e             instr_type;
        opcode_e                 opcode;
        logic [2:0]              funct3;
        logic [6:0]              funct7;
        logic [`REG_ADDR_W-1:0]  rs1;
        logic [`REG_ADDR_W-1:0]  rs2;
        logic [`XLEN-1:0]        imm;    // Sign extended or zero
    } decoded_instr_t;

endpackage

//--- verilog/rv_front_consts.svh
`ifndef RV_FRONT_CONSTS_SVH
`define RV_FRONT_CONSTS_SVH

// Datapath width, also the instruction word width for RV32I
`define XLEN 32

// First fetch address after reset
`define RESET_PC 32'h0000_1000

// Architectural register file
`define NUM_REGS 32
`define REG_ADDR_W 5

// Fixed fetch step, no compressed instructions
`define PC_STEP 32'd4

`endif
